// ==== all.f ====
verilog/dma_regs_pkg.sv
verilog/dma_pkt_pkg.sv
verilog/wdma_req_if.sv
verilog/dma_reg_file.sv
verilog/tx_credit_counter.sv
verilog/wdma_fsm.sv
verilog/mwr_packet_builder.sv
verilog/bmd_dma_top.sv
sim/tb_bmd_dma.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the write DMA testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench stops on an error.

cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_bmd_dma \
    -Mdir obj_dir -o tb_bmd_dma &&
./obj_dir/tb_bmd_dma ||
{
    echo "Build or simulation failed" >&2
    exit 1
}

// ==== sim/tb_bmd_dma.sv ====
// Testbench for the write DMA top level
// Buffer model, credit return, frame reference model and stream checker

`timescale 1ns/1ns
`default_nettype none

module tb_bmd_dma;

    localparam int SPLIT_LEN       = 40;
    localparam int RING_LEN        = 20;
    localparam int RING_BUFS       = 3;
    localparam int RING_FRAMES     = 5;
    localparam int CREDIT_LEN      = 120;
    localparam int IGNORE_LEN      = 33;
    localparam int HOLD_CYCLES     = 40;
    localparam int TOTAL_WORDS     = 2 * SPLIT_LEN + RING_FRAMES * RING_LEN + CREDIT_LEN
                                   + IGNORE_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 2000;

    typedef struct packed {
        logic               sof;
        logic               eof;
        dma_pkt_pkg::beat_t data;
    } exp_beat_t;

    logic                                clk;
    logic                                rst_n;
    logic                                reg_wr_en;
    logic [dma_regs_pkg::REG_ADDR_W-1:0] reg_addr;
    logic [31:0]                         reg_wdata;
    logic                                timeframe_end_rise;
    logic [dma_regs_pkg::BUF_ADDR_W-1:0] xy_buf_addr;
    dma_pkt_pkg::beat_t                  xy_buf_dat = '0;
    logic                                tx_valid;
    logic                                tx_sof;
    logic                                tx_eof;
    dma_pkt_pkg::beat_t                  tx_data;
    logic                                tx_credit = 1'b0;
    logic                                dma_busy;
    logic [15:0]                         frame_count;

    dma_pkt_pkg::beat_t     buf_mem [1024];
    int                     credit_delay [256];
    dma_regs_pkg::dma_cfg_t model_cfg;
    exp_beat_t              exp_q [$];
    int                     due_q [$];
    int                     cycle         = 0;
    int                     eof_seen      = 0;
    int                     pkts_started  = 0;
    int                     pkts_returned = 0;
    int                     frames_sent   = 0;
    logic                   in_pkt        = 1'b0;
    logic                   credit_hold   = 1'b0;
    string                  test_name     = "reset state";

    bmd_dma_top i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .reg_wr_en_i          (reg_wr_en),
        .reg_addr_i           (reg_addr),
        .reg_wdata_i          (reg_wdata),
        .timeframe_end_rise_i (timeframe_end_rise),
        .xy_buf_addr_o        (xy_buf_addr),
        .xy_buf_dat_i         (xy_buf_dat),
        .tx_valid_o           (tx_valid),
        .tx_sof_o             (tx_sof),
        .tx_eof_o             (tx_eof),
        .tx_data_o            (tx_data),
        .tx_credit_i          (tx_credit),
        .dma_busy_o           (dma_busy),
        .frame_count_o        (frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        xy_buf_dat <= buf_mem[xy_buf_addr]; // One cycle read latency
    end

    // Host credit return, one pulse per packet end after a random delay
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst_n && tx_eof) begin
            due_q.push_back(cycle + credit_delay[eof_seen % 256]);
            eof_seen <= eof_seen + 1;
        end
        if (!credit_hold && due_q.size() != 0 && cycle >= due_q[0]) begin
            tx_credit <= 1'b1;
            void'(due_q.pop_front());
        end else begin
            tx_credit <= 1'b0;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_hdr(input dma_pkt_pkg::mwr_hdr_t exp, input dma_pkt_pkg::mwr_hdr_t act);
        if (act !== exp) begin
            fail_run($sformatf({"ERROR %s header: expected addr %h len %0d seq %0d,",
                                " actual addr %h len %0d seq %0d"},
                               test_name, exp.addr, exp.len, exp.seq,
                               act.addr, act.len, act.seq));
        end
    endtask

    task automatic check_beat(input dma_pkt_pkg::beat_t exp, input dma_pkt_pkg::beat_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s payload: expected %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
        end
    endtask

    // Expected beats of frame n, appended to exp_q
    function automatic void build_frame(input int n);
        int                    slot;
        int                    remaining;
        int                    idx;
        int                    words;
        int                    max_words;
        int                    k;
        logic [31:0]           dest;
        dma_pkt_pkg::mwr_hdr_t hdr;
        exp_beat_t             beat;
        max_words = int'(dma_pkt_pkg::MAX_PAYLOAD_WORDS);
        slot      = (model_cfg.num_bufs == '0) ? 0 : n % int'(model_cfg.num_bufs);
        dest      = model_cfg.base_addr + 32'(slot * int'(model_cfg.frame_len) * 8);
        remaining = int'(model_cfg.frame_len);
        idx       = 0;
        while (remaining > 0) begin
            words     = (remaining > max_words) ? max_words : remaining;
            hdr       = '0;
            hdr.addr  = dest + 32'(idx * 8);
            hdr.len   = words[dma_pkt_pkg::PKT_LEN_W-1:0];
            hdr.seq   = n[dma_pkt_pkg::SEQ_W-1:0]; // Frame number mod 256
            beat.sof  = 1'b1;
            beat.eof  = 1'b0;
            beat.data = hdr;
            exp_q.push_back(beat);
            for (k = 0; k < words; k++) begin
                beat.sof  = 1'b0;
                beat.eof  = (k == words - 1);
                beat.data = buf_mem[(idx + k) % 1024];
                exp_q.push_back(beat);
            end
            idx       = idx + words;
            remaining = remaining - words;
        end
    endfunction

    task automatic check_stream_beat();
        exp_beat_t exp;
        if (tx_credit) begin
            pkts_returned++;
        end
        if (!tx_valid) begin
            if (in_pkt) begin
                fail_run("Packet broken, tx_valid_o dropped before tx_eof_o");
            end else if (tx_sof || tx_eof) begin
                fail_run("tx_sof_o or tx_eof_o raised without tx_valid_o");
            end
        end else if (exp_q.size() == 0) begin
            fail_run("Beat on the transmit stream while no packet was expected");
        end else begin
            exp = exp_q.pop_front();
            check_bit("tx_sof_o", exp.sof, tx_sof);
            check_bit("tx_eof_o", exp.eof, tx_eof);
            if (exp.sof) begin
                check_hdr(dma_pkt_pkg::mwr_hdr_t'(exp.data), dma_pkt_pkg::mwr_hdr_t'(tx_data));
                pkts_started++;
                in_pkt = 1'b1;
            end else begin
                check_beat(exp.data, tx_data);
            end
            if (exp.eof) begin
                in_pkt = 1'b0;
            end
        end
        if (pkts_started - pkts_returned > int'(dma_pkt_pkg::INIT_CREDITS)) begin
            fail_run("More packets started than credits allow");
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                pkts_started  = 0;
                pkts_returned = 0;
                in_pkt        = 1'b0;
            end else begin
                check_stream_beat();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic apply_reset();
        while (pkts_started != pkts_returned) @(negedge clk); // Let credits drain
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        model_cfg   = '0;
        frames_sent = 0;
        @(negedge clk);
        check_bit("tx_valid_o after reset", 1'b0, tx_valid);
        check_bit("tx_sof_o after reset", 1'b0, tx_sof);
        check_bit("tx_eof_o after reset", 1'b0, tx_eof);
        check_bit("dma_busy_o after reset", 1'b0, dma_busy);
        check_count("frame_count_o after reset", 16'd0, frame_count);
    endtask

    task automatic write_reg(input logic [dma_regs_pkg::REG_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        reg_wr_en <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr_en <= 1'b0;
        case (addr)
            dma_regs_pkg::REG_CTRL:      model_cfg.enable    = data[0];
            dma_regs_pkg::REG_BASE_ADDR: model_cfg.base_addr = data;
            dma_regs_pkg::REG_FRAME_LEN: model_cfg.frame_len = data[dma_regs_pkg::FRAME_LEN_W-1:0];
            default:                     model_cfg.num_bufs  = data[dma_regs_pkg::RING_W-1:0];
        endcase
    endtask

    task automatic configure(input logic [31:0] base, input int len, input int bufs,
                             input logic en);
        write_reg(dma_regs_pkg::REG_BASE_ADDR, base);
        write_reg(dma_regs_pkg::REG_FRAME_LEN, 32'(len));
        write_reg(dma_regs_pkg::REG_NUM_BUFS, 32'(bufs));
        write_reg(dma_regs_pkg::REG_CTRL, {31'd0, en});
    endtask

    task automatic fire_trigger(input logic accept);
        if (accept) begin
            build_frame(frames_sent);
            frames_sent++;
        end
        @(posedge clk);
        timeframe_end_rise <= 1'b1;
        @(posedge clk);
        timeframe_end_rise <= 1'b0;
        @(negedge clk);
        if (accept) begin
            check_bit("dma_busy_o after trigger", 1'b1, dma_busy);
        end
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0 || dma_busy);
    endtask

    initial begin
        int i;
        void'($urandom(96));
        for (i = 0; i < 1024; i++) begin
            buf_mem[i] = {$urandom, $urandom};
        end
        for (i = 0; i < 256; i++) begin
            credit_delay[i] = 1 + int'($urandom % 10); // 1 to 10 cycles
        end
        rst_n              = 1'b0;
        reg_wr_en          = 1'b0;
        reg_addr           = '0;
        reg_wdata          = '0;
        timeframe_end_rise = 1'b0;
        apply_reset();

        test_name = "packet split";
        configure(32'h1000_0000, SPLIT_LEN, 2, 1'b1);
        fire_trigger(1'b1);
        wait_idle();
        check_count("frame_count_o", 16'd1, frame_count);
        fire_trigger(1'b1);
        wait_idle();
        check_count("frame_count_o", 16'd2, frame_count);

        test_name = "ring wrap";
        apply_reset();
        configure(32'h2000_0100, RING_LEN, RING_BUFS, 1'b1);
        for (i = 0; i < RING_FRAMES; i++) begin
            fire_trigger(1'b1);
            wait_idle();
        end
        check_count("frame_count_o", 16'(RING_FRAMES), frame_count);

        test_name = "credit limit";
        apply_reset();
        configure(32'h3000_0000, CREDIT_LEN, 1, 1'b1);
        credit_hold = 1'b1;
        fire_trigger(1'b1);
        while (pkts_started < int'(dma_pkt_pkg::INIT_CREDITS)) @(negedge clk);
        repeat (HOLD_CYCLES) @(negedge clk);
        check_count("packets started with credits held",
                    16'(dma_pkt_pkg::INIT_CREDITS), 16'(pkts_started));
        credit_hold = 1'b0;
        wait_idle();
        check_count("frame_count_o", 16'd1, frame_count);

        test_name = "ignored triggers";
        apply_reset();
        configure(32'h4000_0000, IGNORE_LEN, 2, 1'b0);
        fire_trigger(1'b0);                           // Enable clear
        repeat (20) @(negedge clk);
        check_bit("dma_busy_o", 1'b0, dma_busy);
        write_reg(dma_regs_pkg::REG_FRAME_LEN, 32'd0);
        write_reg(dma_regs_pkg::REG_CTRL, 32'd1);
        fire_trigger(1'b0);                           // Zero frame length
        repeat (20) @(negedge clk);
        check_bit("dma_busy_o", 1'b0, dma_busy);
        check_count("frame_count_o", 16'd0, frame_count);
        write_reg(dma_regs_pkg::REG_FRAME_LEN, 32'(IGNORE_LEN));
        fire_trigger(1'b1);
        fire_trigger(1'b0);                           // Lands while busy
        check_bit("dma_busy_o during frame", 1'b1, dma_busy);
        wait_idle();
        repeat (20) @(negedge clk);
        check_bit("dma_busy_o", 1'b0, dma_busy);
        check_count("frame_count_o", 16'd1, frame_count);

        if (exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("Expected beats were never sent on the stream");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bmd_dma_top.sv ====
// Bus master write DMA top level
// Register file, credit counter, frame FSM and packet builder on plain ports

`timescale 1ns/1ns
`default_nettype none

module bmd_dma_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 reg_wr_en_i,
    input  wire [dma_regs_pkg::REG_ADDR_W-1:0]  reg_addr_i,
    input  wire [31:0]                          reg_wdata_i,
    input  wire                                 timeframe_end_rise_i,
    output logic [dma_regs_pkg::BUF_ADDR_W-1:0] xy_buf_addr_o,
    input  wire dma_pkt_pkg::beat_t             xy_buf_dat_i,
    output logic                                tx_valid_o,
    output logic                                tx_sof_o,
    output logic                                tx_eof_o,
    output dma_pkt_pkg::beat_t                  tx_data_o,
    input  wire                                 tx_credit_i,
    output logic                                dma_busy_o,
    output logic [15:0]                         frame_count_o
);

    dma_regs_pkg::dma_cfg_t cfg;
    logic                   credit_take;
    logic                   credit_avail;

    wdma_req_if req_bus ();

    dma_reg_file i_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_en_i (reg_wr_en_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .cfg_o       (cfg)
    );

    tx_credit_counter i_credit (
        .clk      (clk),
        .rst_n    (rst_n),
        .take_i   (credit_take),
        .return_i (tx_credit_i),
        .avail_o  (credit_avail)
    );

    wdma_fsm i_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_i          (cfg),
        .trigger_i      (timeframe_end_rise_i),
        .credit_avail_i (credit_avail),
        .credit_take_o  (credit_take),
        .req            (req_bus.fsm),
        .busy_o         (dma_busy_o),
        .frame_count_o  (frame_count_o)
    );

    mwr_packet_builder i_builder (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req_bus.builder),
        .xy_buf_addr_o (xy_buf_addr_o),
        .xy_buf_dat_i  (xy_buf_dat_i),
        .tx_valid_o    (tx_valid_o),
        .tx_sof_o      (tx_sof_o),
        .tx_eof_o      (tx_eof_o),
        .tx_data_o     (tx_data_o)
    );

endmodule

`default_nettype wire

// ==== verilog/mwr_packet_builder.sv ====
// Memory write packet builder
// Sends the header beat the cycle after start, then len payload beats read
// from xy_buf, with each read issued one cycle ahead of its beat

`timescale 1ns/1ns
`default_nettype none

module mwr_packet_builder (
    input  wire                                 clk,
    input  wire                                 rst_n,
    wdma_req_if.builder                         req,
    output logic [dma_regs_pkg::BUF_ADDR_W-1:0] xy_buf_addr_o,
    input  wire dma_pkt_pkg::beat_t             xy_buf_dat_i,
    output logic                                tx_valid_o,
    output logic                                tx_sof_o,
    output logic                                tx_eof_o,
    output dma_pkt_pkg::beat_t                  tx_data_o
);

    logic                              active_q;
    logic                              hdr_phase_q;
    logic [dma_pkt_pkg::PKT_LEN_W-1:0] left_q; // Payload beats still to send
    dma_pkt_pkg::mwr_hdr_t             hdr_q;
    logic                              last_beat;

    assign last_beat = active_q && !hdr_phase_q && (left_q == 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q      <= 1'b0;
            hdr_phase_q   <= 1'b0;
            xy_buf_addr_o <= '0;
        end else if (req.start) begin
            active_q      <= 1'b1;
            hdr_phase_q   <= 1'b1;
            xy_buf_addr_o <= req.buf_addr; // First read during the header beat
        end else begin
            hdr_phase_q <= 1'b0;
            if (active_q) begin
                xy_buf_addr_o <= xy_buf_addr_o + 1;
            end
            if (last_beat) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            hdr_q.rsvd <= '0;
            hdr_q.seq  <= req.seq;
            hdr_q.len  <= req.len;
            hdr_q.addr <= req.addr;
            left_q     <= req.len;
        end else if (active_q && !hdr_phase_q) begin
            left_q <= left_q - 1;
        end
    end

    assign tx_valid_o = active_q;
    assign tx_sof_o   = hdr_phase_q;
    assign tx_eof_o   = last_beat;
    assign req.done   = last_beat;
    assign tx_data_o  = hdr_phase_q ? dma_pkt_pkg::beat_t'(hdr_q) : xy_buf_dat_i;

endmodule

`default_nettype wire

// ==== verilog/wdma_fsm.sv ====
// Frame state machine of the write DMA
// Splits each triggered frame into packets of up to MAX_PAYLOAD_WORDS words,
// requests them one at a time under credit control and walks the buffer ring

`timescale 1ns/1ns
`default_nettype none

module wdma_fsm (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire dma_regs_pkg::dma_cfg_t cfg_i,
    input  wire                         trigger_i,
    input  wire                         credit_avail_i,
    output logic                        credit_take_o,
    wdma_req_if.fsm                     req,
    output logic                        busy_o,
    output logic [15:0]                 frame_count_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CREDIT,
        SEND,        // Packet streaming, more to follow
        NEXT         // Last packet of the frame streaming
    } state_t;

    state_t                                                   state_q;
    logic                                                     trigger_q;
    logic                                                     trigger_rise;
    logic                                                     frame_ok;
    logic                                                     issue;
    logic                                                     last_pkt;
    logic [dma_regs_pkg::FRAME_LEN_W-1:0]                     remaining_q;
    logic [dma_regs_pkg::BUF_ADDR_W-1:0]                      word_idx_q;
    logic [31:0]                                              pkt_addr_q;
    logic [dma_regs_pkg::RING_W-1:0]                          slot_q;
    logic [dma_regs_pkg::RING_W-1:0]                          slot_next;
    logic [15:0]                                              frame_count_q;
    logic [dma_regs_pkg::RING_W+dma_regs_pkg::FRAME_LEN_W-1:0] slot_words;
    logic [31:0]                                              frame_addr;
    logic [dma_regs_pkg::FRAME_LEN_W-1:0]                     max_words;
    logic [dma_regs_pkg::FRAME_LEN_W-1:0]                     pkt_words;
    logic [31:0]                                              pkt_bytes;

    assign trigger_rise = trigger_i && !trigger_q;
    assign frame_ok     = cfg_i.enable && (cfg_i.frame_len != '0);

    // Byte offset of the current ring slot
    assign slot_words = {{dma_regs_pkg::FRAME_LEN_W{1'b0}}, slot_q}
                      * {{dma_regs_pkg::RING_W{1'b0}}, cfg_i.frame_len};
    assign frame_addr = cfg_i.base_addr + 32'({slot_words, 3'b000});
    assign slot_next  = slot_q + 1;

    assign max_words = {{(dma_regs_pkg::FRAME_LEN_W-dma_pkt_pkg::PKT_LEN_W){1'b0}},
                        dma_pkt_pkg::MAX_PAYLOAD_WORDS};
    assign last_pkt  = (remaining_q <= max_words);
    assign pkt_words = last_pkt ? remaining_q : max_words;
    assign pkt_bytes = 32'({pkt_words, 3'b000});

    assign issue         = (state_q == WAIT_CREDIT) && credit_avail_i;
    assign credit_take_o = issue;

    assign req.start    = issue;
    assign req.addr     = pkt_addr_q;
    assign req.len      = pkt_words[dma_pkt_pkg::PKT_LEN_W-1:0];
    assign req.buf_addr = word_idx_q;
    assign req.seq      = frame_count_q[dma_pkt_pkg::SEQ_W-1:0]; // Frame number mod 256

    assign busy_o        = (state_q != IDLE);
    assign frame_count_o = frame_count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= IDLE;
            trigger_q     <= 1'b0;
            slot_q        <= '0;
            frame_count_q <= '0;
        end else begin
            trigger_q <= trigger_i;
            case (state_q)
                IDLE: begin
                    if (trigger_rise && frame_ok) begin
                        state_q <= WAIT_CREDIT;
                    end
                end
                WAIT_CREDIT: begin
                    if (credit_avail_i) begin
                        state_q <= last_pkt ? NEXT : SEND;
                    end
                end
                SEND: begin
                    if (req.done) begin
                        state_q <= WAIT_CREDIT;
                    end
                end
                NEXT: begin
                    if (req.done) begin
                        state_q       <= IDLE;
                        frame_count_q <= frame_count_q + 1;
                        slot_q        <= (slot_next >= cfg_i.num_bufs) ? '0 : slot_next;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Frame position, loaded while idle so the accepting edge captures it
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            remaining_q <= cfg_i.frame_len;
            word_idx_q  <= '0;
            pkt_addr_q  <= frame_addr;
        end else if (issue) begin
            remaining_q <= remaining_q - pkt_words;
            word_idx_q  <= word_idx_q + pkt_words;
            pkt_addr_q  <= pkt_addr_q + pkt_bytes;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tx_credit_counter.sv ====
// Transmit credit counter
// Starts full, one credit per packet, one back per host return pulse

`timescale 1ns/1ns
`default_nettype none

module tx_credit_counter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  take_i,
    input  wire  return_i,
    output logic avail_o
);

    logic [dma_pkt_pkg::CREDIT_W-1:0] credits_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits_q <= dma_pkt_pkg::INIT_CREDITS;
        end else if (take_i && !return_i) begin
            if (credits_q != '0) begin
                credits_q <= credits_q - 1;
            end
        end else if (return_i && !take_i) begin
            if (credits_q != dma_pkt_pkg::INIT_CREDITS) begin // Saturate at the start value
                credits_q <= credits_q + 1;
            end
        end
    end

    assign avail_o = (credits_q != '0);

endmodule

`default_nettype wire

// ==== verilog/dma_reg_file.sv ====
// DMA control registers
// Host write port into enable, ring base, frame length and ring size

`timescale 1ns/1ns
`default_nettype none

module dma_reg_file (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                reg_wr_en_i,
    input  wire [dma_regs_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  wire [31:0]                         reg_wdata_i,
    output dma_regs_pkg::dma_cfg_t             cfg_o
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_o <= '0;
        end else if (reg_wr_en_i) begin
            case (reg_addr_i)
                dma_regs_pkg::REG_CTRL: begin
                    cfg_o.enable <= reg_wdata_i[0];
                end
                dma_regs_pkg::REG_BASE_ADDR: begin
                    cfg_o.base_addr <= reg_wdata_i;
                end
                dma_regs_pkg::REG_FRAME_LEN: begin
                    cfg_o.frame_len <= reg_wdata_i[dma_regs_pkg::FRAME_LEN_W-1:0];
                end
                dma_regs_pkg::REG_NUM_BUFS: begin
                    cfg_o.num_bufs <= reg_wdata_i[dma_regs_pkg::RING_W-1:0];
                end
                default: begin
                    cfg_o <= cfg_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wdma_req_if.sv ====
// Packet request from the frame FSM to the packet builder
// start is a one-cycle pulse with stable fields, done marks the last beat

`timescale 1ns/1ns
`default_nettype none

interface wdma_req_if ();

    logic                                start;
    logic [31:0]                         addr;
    logic [dma_pkt_pkg::PKT_LEN_W-1:0]   len;
    logic [dma_regs_pkg::BUF_ADDR_W-1:0] buf_addr; // First xy_buf word
    logic [dma_pkt_pkg::SEQ_W-1:0]       seq;
    logic                                done;

    modport fsm (
        output start, addr, len, buf_addr, seq,
        input  done
    );

    modport builder (
        input  start, addr, len, buf_addr, seq,
        output done
    );

endinterface

`default_nettype wire

// ==== verilog/dma_pkt_pkg.sv ====
// Memory write packet format
// Stream beat type, header layout and the payload and credit limits

`default_nettype none

package dma_pkt_pkg;

    localparam int BEAT_W    = 64;
    localparam int PKT_LEN_W = 8;
    localparam int SEQ_W     = 8;
    localparam int CREDIT_W  = 3;

    localparam logic [PKT_LEN_W-1:0] MAX_PAYLOAD_WORDS = 8'd16;
    localparam logic [CREDIT_W-1:0]  INIT_CREDITS      = 3'd4;

    typedef logic [BEAT_W-1:0] beat_t;

    // One header beat, addr in the low bits
    typedef struct packed {
        logic [BEAT_W-32-PKT_LEN_W-SEQ_W-1:0] rsvd; // Always zero
        logic [SEQ_W-1:0]                     seq;
        logic [PKT_LEN_W-1:0]                 len;  // Payload words
        logic [31:0]                          addr; // Byte address
    } mwr_hdr_t;

endpackage

`default_nettype wire

// ==== verilog/dma_regs_pkg.sv ====
// Write DMA register map
// Address decode constants and the configuration held by the register file

`default_nettype none

package dma_regs_pkg;

    localparam int REG_ADDR_W = 2;

    localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 2'd0; // Bit 0 enables triggers
    localparam logic [REG_ADDR_W-1:0] REG_BASE_ADDR = 2'd1; // Ring start, byte address
    localparam logic [REG_ADDR_W-1:0] REG_FRAME_LEN = 2'd2; // 64-bit words per frame
    localparam logic [REG_ADDR_W-1:0] REG_NUM_BUFS  = 2'd3; // Buffers in the ring

    localparam int BUF_ADDR_W  = 10; // xy_buf word address
    localparam int FRAME_LEN_W = 10;
    localparam int RING_W      = 8;

    // Live configuration, zero after reset
    typedef struct packed {
        logic                   enable;
        logic [31:0]            base_addr;
        logic [FRAME_LEN_W-1:0] frame_len;
        logic [RING_W-1:0]      num_bufs;
    } dma_cfg_t;

endpackage

`default_nettype wire
